/* build.f */
common/rvv_pkg.sv
common/valu_pkg.sv
simd_alu/simd_alu.sv
rtl/valu_insn_queue.sv
rtl/valu_issue.sv
rtl/valu_result_queue.sv
rtl/valu.sv
verif/valu_checker.sv
verif/tb_clock_gen.sv
verif/tb_valu.sv

/* verif/tb_valu.sv */
`timescale 1ns/100ps

module tb_valu;
  import valu_pkg::*;
  import rvv_pkg::*;

  localparam int unsigned NumOps = 40;
  localparam logic [31:0] Seed   = 32'd5;
  // Twice the four words an operation can take, at 6 cycles each, plus startup
  localparam int unsigned TimeoutCycles = NumOps * 8 * 6 + 200;
  // Cycles the grant stays withheld, long enough for four operations to pile up
  localparam int unsigned HoldCycles = 30;

  logic               clk;
  logic               rst_n;
  valu_op_t           op;
  logic               op_valid;
  logic               ready;
  elen_t [1:0]        operand;
  logic [1:0]         operand_valid;
  logic [1:0]         operand_ready;
  logic               result_req;
  valu_result_t       result;
  logic               result_gnt;
  logic [NrVInsn-1:0] done;

  // Expected writes in acceptance order, with a flag on each last word
  valu_result_t exp_q [$];
  logic         last_q [$];
  // Operand words waiting in the vs1 and vs2 queues
  elen_t        vs1_q [$];
  elen_t        vs2_q [$];

  logic [31:0] seq_s;
  logic [31:0] drv_s;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          stall_cycles = 0;
  logic        hold_gnt = 1'b0;
  logic        saw_full = 1'b0;

  tb_clock_gen i_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  valu DUT (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .op_i            (op),
    .op_valid_i      (op_valid),
    .ready_o         (ready),
    .operand_i       (operand),
    .operand_valid_i (operand_valid),
    .operand_ready_o (operand_ready),
    .result_req_o    (result_req),
    .result_o        (result),
    .result_gnt_i    (result_gnt),
    .done_o          (done)
  );

  bind valu valu_checker u_checker (.*);

  function automatic logic [31:0] xorshift(logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic elen_t lane_mask(int lw);
    return (lw == 64) ? '1 : ((64'd1 << lw) - 1);
  endfunction

  // Per-lane reference, each lane wrapped to its own width
  function automatic elen_t expect_word(alu_op_e opc, elen_t a, elen_t b, vew_e sew);
    int                 lw;
    elen_t              m;
    elen_t              la;
    elen_t              lb;
    elen_t              r;
    elen_t              word;
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    lw   = 8 << sew;
    m    = lane_mask(lw);
    word = '0;
    for (int l = 0; l < 64 / lw; l++) begin
      la = (a >> (l * lw)) & m;
      lb = (b >> (l * lw)) & m;
      // Sign extension of the lane for signed compares
      sa = $signed(la << (64 - lw)) >>> (64 - lw);
      sb = $signed(lb << (64 - lw)) >>> (64 - lw);
      case (opc)
        VAND:    r = la & lb;
        VOR:     r = la | lb;
        VXOR:    r = la ^ lb;
        VADD:    r = la + lb;
        VSUB:    r = lb - la;
        VRSUB:   r = la - lb;
        VMIN:    r = (sa < sb) ? la : lb;
        VMINU:   r = (la < lb) ? la : lb;
        VMAX:    r = (sa < sb) ? lb : la;
        VMAXU:   r = (la < lb) ? lb : la;
        default: r = '0;
      endcase
      word = word | ((r & m) << (l * lw));
    end
    return word;
  endfunction

  // Low element of the scalar copied to every lane
  function automatic elen_t replicate(elen_t s, vew_e sew);
    int    lw;
    elen_t word;
    lw   = 8 << sew;
    word = '0;
    for (int l = 0; l < 64 / lw; l++) begin
      word = word | ((s & lane_mask(lw)) << (l * lw));
    end
    return word;
  endfunction

  // Random word, or lanes at the signed and unsigned extremes
  task automatic make_operand(input vew_e sew, output elen_t w);
    int    lw;
    elen_t v;
    lw    = 8 << sew;
    w     = '0;
    seq_s = xorshift(seq_s);
    if (seq_s[0]) begin
      w[63:32] = seq_s;
      seq_s    = xorshift(seq_s);
      w[31:0]  = seq_s;
    end else begin
      for (int l = 0; l < 64 / lw; l++) begin
        seq_s = xorshift(seq_s);
        case (seq_s[1:0])
          2'd0:    v = 64'd1 << (lw - 1);
          2'd1:    v = (64'd1 << (lw - 1)) - 1;
          2'd2:    v = '1;
          default: v = '0;
        endcase
        w = w | ((v & lane_mask(lw)) << (l * lw));
      end
    end
  endtask

  // Sequencer, one operation per loop, with the model filled at generation
  initial begin
    valu_op_t     o;
    valu_result_t want;
    elen_t        a;
    elen_t        b;
    int           epw;
    int           rem;
    int           elems;
    int           word;
    op            = '0;
    op_valid      = 1'b0;
    operand       = '0;
    operand_valid = '0;
    result_gnt    = 1'b0;
    seq_s         = Seed;
    drv_s         = Seed;
    @(posedge rst_n);
    for (int n = 0; n < NumOps; n++) begin
      seq_s           = xorshift(seq_s);
      o               = '0;
      o.id            = vid_t'(n);
      o.op            = alu_op_e'(n % 10);
      o.vsew          = vew_e'((n / 10) % 4);
      epw             = 8 >> o.vsew;
      o.vl            = vlen_t'(seq_s % (4 * epw) + 1);
      o.vd            = vreg_t'(seq_s >> 8);
      o.use_scalar_op = (seq_s[17:16] == 2'b00);
      o.use_vs1       = !o.use_scalar_op;
      o.use_vs2       = 1'b1;
      make_operand(o.vsew, o.scalar_op);
      rem  = o.vl;
      word = 0;
      while (rem > 0) begin
        elems = (rem < epw) ? rem : epw;
        make_operand(o.vsew, a);
        make_operand(o.vsew, b);
        if (o.use_scalar_op) begin
          a = replicate(o.scalar_op, o.vsew);
        end else begin
          vs1_q.push_back(a);
        end
        vs2_q.push_back(b);
        want.id    = o.id;
        want.addr  = vaddr_t'(o.vd * VRegWords + word);
        want.wdata = expect_word(o.op, a, b, o.vsew);
        want.be    = strb_t'((16'd1 << (elems << o.vsew)) - 1);
        exp_q.push_back(want);
        rem = rem - elems;
        last_q.push_back(rem == 0);
        word++;
      end
      // Grant withheld for a fixed stretch from here so the queues fill up
      if (n == 20) begin
        hold_gnt = 1'b1;
      end
      @(negedge clk);
      op_valid = 1'b0;
      while (!ready) @(negedge clk);
      op       = o;
      op_valid = 1'b1;
    end
    @(negedge clk);
    op_valid = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);
    if (!saw_full) begin
      $display("ready_o never dropped while the grant was withheld");
      errors++;
    end
    $display("Writes checked: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, DUT.u_checker.fails);
    if (errors == 0 && DUT.u_checker.fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Operand queues and register-file grant
  always @(negedge clk) begin
    if (rst_n) begin
      drv_s            = xorshift(drv_s);
      operand_valid[0] = (vs1_q.size() != 0) && (drv_s[1:0] != 2'b00);
      operand_valid[1] = (vs2_q.size() != 0) && (drv_s[3:2] != 2'b00);
      operand[0]       = (vs1_q.size() != 0) ? vs1_q[0] : '0;
      operand[1]       = (vs2_q.size() != 0) ? vs2_q[0] : '0;
      if (hold_gnt) begin
        result_gnt = 1'b0;
        if (!ready) begin
          saw_full = 1'b1;
        end
        stall_cycles++;
        if (stall_cycles > HoldCycles) begin
          hold_gnt = 1'b0;
        end
      end else begin
        result_gnt = (drv_s[5:4] != 2'b00);
      end
    end
  end

  // Values are sampled before the edge updates any state
  always @(posedge clk) begin
    valu_result_t       want;
    logic [NrVInsn-1:0] want_done;
    if (rst_n) begin
      cycles++;
      want_done = '0;
      if (operand_ready[0]) begin
        assert (vs1_q.size() != 0) else begin
          $display("vs1 acknowledged while its operand queue was empty");
          errors++;
        end
        if (vs1_q.size() != 0) void'(vs1_q.pop_front());
      end
      if (operand_ready[1]) begin
        assert (vs2_q.size() != 0) else begin
          $display("vs2 acknowledged while its operand queue was empty");
          errors++;
        end
        if (vs2_q.size() != 0) void'(vs2_q.pop_front());
      end
      if (result_req && result_gnt) begin
        if (exp_q.size() == 0) begin
          $display("Write granted with no write expected");
          errors++;
        end else begin
          want = exp_q.pop_front();
          checks++;
          assert (result.wdata == want.wdata) else begin
            $display("Error: result_o.wdata expected %h got %h", want.wdata, result.wdata);
            errors++;
          end
          assert (result.addr == want.addr) else begin
            $display("Error: result_o.addr expected %h got %h", want.addr, result.addr);
            errors++;
          end
          assert (result.be == want.be) else begin
            $display("Error: result_o.be expected %h got %h", want.be, result.be);
            errors++;
          end
          assert (result.id == want.id) else begin
            $display("Error: result_o.id expected %h got %h", want.id, result.id);
            errors++;
          end
          if (last_q.pop_front()) begin
            want_done[want.id] = 1'b1;
          end
        end
      end
      assert (done == want_done) else begin
        $display("Error: done_o expected %h got %h", want_done, done);
        errors++;
      end
      if (cycles >= TimeoutCycles) begin
        $display("Run stopped after %0d cycles with %0d writes outstanding",
                 cycles, exp_q.size());
        $display("Writes checked: %0d, errors: %0d", checks, errors);
        $display("Test failures found");
        $finish;
      end
    end
  end

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int unsigned HalfPeriodNs = 50,
  parameter int unsigned ResetCycles  = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriodNs) clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* verif/valu_checker.sv */
`timescale 1ns/100ps

module valu_checker (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           op_valid_i,
  input  logic                           ready_o,
  input  logic [1:0]                     operand_ready_o,
  input  logic                           result_req_o,
  input  valu_pkg::valu_result_t         result_o,
  input  logic                           result_gnt_i,
  input  logic [valu_pkg::NrVInsn-1:0]   done_o
);
  import valu_pkg::*;

  int unsigned fails = 0;

  // Accepted operations that have not pulsed done yet
  logic [2:0] outstanding_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_q + 3'(op_valid_i && ready_o) - 3'(done_o != '0);
    end
  end

  // A waiting request holds its word until granted
  req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_req_o && !result_gnt_i |=> result_req_o && $stable(result_o))
    else begin
      $error("Result payload or request changed while waiting for grant");
      fails++;
    end

  // Nothing leaves the unit while reset is held
  reset_quiet_a: assert property (@(posedge clk_i)
    !rst_ni |-> !result_req_o && operand_ready_o == '0 && done_o == '0)
    else begin
      $error("Request, operand acknowledge or done seen during reset");
      fails++;
    end

  done_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(done_o))
    else begin
      $error("More than one done bit set in one cycle");
      fails++;
    end

  // Queue is full exactly when four operations are in flight
  ready_full_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ready_o == (outstanding_q != InsnQueueDepth))
    else begin
      $error("ready_o does not match the number of outstanding operations");
      fails++;
    end

endmodule

/* rtl/valu.sv */
`timescale 1ns/100ps

module valu (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Sequencer side
  input  valu_pkg::valu_op_t             op_i,
  input  logic                           op_valid_i,
  output logic                           ready_o,
  // Operand queues, index 0 is vs1 and index 1 is vs2
  input  rvv_pkg::elen_t [1:0]           operand_i,
  input  logic [1:0]                     operand_valid_i,
  output logic [1:0]                     operand_ready_o,
  // Register file write port
  output logic                           result_req_o,
  output valu_pkg::valu_result_t         result_o,
  input  logic                           result_gnt_i,
  // One pulse per finished instruction
  output logic [valu_pkg::NrVInsn-1:0]   done_o
);
  import valu_pkg::*;
  import rvv_pkg::*;

  // Queue to issue stage
  valu_op_t     issue_op;
  logic         issue_valid;
  vlen_t        issue_remaining;
  logic         issue_word_done;
  vlen_t        issue_elems;

  // Issue stage to result queue
  logic         push;
  valu_result_t push_data;
  logic         rq_full;
  logic         commit;

  // Datapath
  elen_t        alu_a;
  elen_t        alu_b;
  alu_op_e      alu_op;
  vew_e         alu_vsew;
  elen_t        alu_res;

  valu_insn_queue i_insn_queue (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .op_i              (op_i),
    .op_valid_i        (op_valid_i),
    .ready_o           (ready_o),
    .issue_op_o        (issue_op),
    .issue_valid_o     (issue_valid),
    .issue_remaining_o (issue_remaining),
    .issue_word_done_i (issue_word_done),
    .issue_elems_i     (issue_elems),
    .commit_i          (commit),
    .done_o            (done_o)
  );

  valu_issue i_issue (
    .issue_op_i        (issue_op),
    .issue_valid_i     (issue_valid),
    .issue_remaining_i (issue_remaining),
    .issue_word_done_o (issue_word_done),
    .issue_elems_o     (issue_elems),
    .operand_i         (operand_i),
    .operand_valid_i   (operand_valid_i),
    .operand_ready_o   (operand_ready_o),
    .rq_full_i         (rq_full),
    .push_o            (push),
    .push_data_o       (push_data),
    .alu_a_o           (alu_a),
    .alu_b_o           (alu_b),
    .alu_op_o          (alu_op),
    .alu_vsew_o        (alu_vsew),
    .alu_res_i         (alu_res)
  );

  simd_alu i_simd_alu (
    .operand_a_i (alu_a),
    .operand_b_i (alu_b),
    .op_i        (alu_op),
    .vew_i       (alu_vsew),
    .result_o    (alu_res)
  );

  valu_result_queue i_result_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (push),
    .push_data_i  (push_data),
    .full_o       (rq_full),
    .result_req_o (result_req_o),
    .result_o     (result_o),
    .result_gnt_i (result_gnt_i),
    .commit_o     (commit)
  );

endmodule

/* rtl/valu_result_queue.sv */
`timescale 1ns/100ps

module valu_result_queue (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     push_i,
  input  valu_pkg::valu_result_t   push_data_i,
  output logic                     full_o,
  output logic                     result_req_o,
  output valu_pkg::valu_result_t   result_o,
  input  logic                     result_gnt_i,
  output logic                     commit_o
);
  import valu_pkg::*;

  valu_result_t              mem_q [ResultQueueDepth];
  logic [ResultPtrWidth-1:0] wr_pnt_q;
  logic [ResultPtrWidth-1:0] rd_pnt_q;
  logic [ResultPtrWidth:0]   cnt_q;
  logic                      pop;

  assign full_o       = (cnt_q == ResultQueueDepth);
  // Head entry is presented until it gets a grant
  assign result_req_o = (cnt_q != '0);
  assign result_o     = mem_q[rd_pnt_q];
  assign pop          = result_req_o && result_gnt_i;
  assign commit_o     = pop;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_pnt_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_pnt_q <= wr_pnt_q + 1'b1;
      end
      if (pop) begin
        rd_pnt_q <= rd_pnt_q + 1'b1;
      end
      // Simultaneous push and pop keep the count
      case ({push_i, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

/* rtl/valu_issue.sv */
`timescale 1ns/100ps

module valu_issue (
  input  valu_pkg::valu_op_t       issue_op_i,
  input  logic                     issue_valid_i,
  input  valu_pkg::vlen_t          issue_remaining_i,
  output logic                     issue_word_done_o,
  output valu_pkg::vlen_t          issue_elems_o,
  input  rvv_pkg::elen_t [1:0]     operand_i,
  input  logic [1:0]               operand_valid_i,
  output logic [1:0]               operand_ready_o,
  input  logic                     rq_full_i,
  output logic                     push_o,
  output valu_pkg::valu_result_t   push_data_o,
  output rvv_pkg::elen_t           alu_a_o,
  output rvv_pkg::elen_t           alu_b_o,
  output rvv_pkg::alu_op_e         alu_op_o,
  output rvv_pkg::vew_e            alu_vsew_o,
  input  rvv_pkg::elen_t           alu_res_i
);
  import valu_pkg::*;
  import rvv_pkg::*;

  elen_t      scalar_rep;
  logic       operands_ok;
  logic       fire;
  vlen_t      word_elems;
  vlen_t      done_elems;
  vlen_t      word_idx;
  logic [3:0] nbytes;
  strb_t      be;

  // Scalar low element copied into every lane
  always_comb begin
    case (issue_op_i.vsew)
      EW8:     scalar_rep = {8{issue_op_i.scalar_op[7:0]}};
      EW16:    scalar_rep = {4{issue_op_i.scalar_op[15:0]}};
      EW32:    scalar_rep = {2{issue_op_i.scalar_op[31:0]}};
      default: scalar_rep = issue_op_i.scalar_op;
    endcase
  end

  assign alu_a_o    = issue_op_i.use_scalar_op ? scalar_rep : operand_i[0];
  assign alu_b_o    = operand_i[1];
  assign alu_op_o   = issue_op_i.op;
  assign alu_vsew_o = issue_op_i.vsew;

  // Unused operand queues do not hold up issue
  assign operands_ok = (operand_valid_i[0] || !issue_op_i.use_vs1) &&
                       (operand_valid_i[1] || !issue_op_i.use_vs2);
  assign fire        = issue_valid_i && !rq_full_i && operands_ok;

  assign operand_ready_o   = fire ? {issue_op_i.use_vs2, issue_op_i.use_vs1} : 2'b00;
  assign push_o            = fire;
  assign issue_word_done_o = fire;

  // Tail word carries only what is left of vl
  assign word_elems    = elems_per_word(issue_op_i.vsew);
  assign issue_elems_o = (issue_remaining_i < word_elems) ? issue_remaining_i : word_elems;

  // Earlier words were all full, so this divides evenly
  assign done_elems = issue_op_i.vl - issue_remaining_i;
  assign word_idx   = done_elems >> (2'(EW64) - 2'(issue_op_i.vsew));

  // Bytes covered by the elements of this word
  assign nbytes = 4'(issue_elems_o) << issue_op_i.vsew;

  always_comb begin
    for (int b = 0; b < $bits(strb_t); b++) begin
      be[b] = (4'(b) < nbytes);
    end
  end

  always_comb begin
    push_data_o.id    = issue_op_i.id;
    push_data_o.addr  = vaddr_t'(issue_op_i.vd) * vaddr_t'(VRegWords) + vaddr_t'(word_idx);
    push_data_o.wdata = alu_res_i;
    push_data_o.be    = be;
  end

endmodule

/* rtl/valu_insn_queue.sv */
`timescale 1ns/100ps

module valu_insn_queue (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  valu_pkg::valu_op_t             op_i,
  input  logic                           op_valid_i,
  output logic                           ready_o,
  output valu_pkg::valu_op_t             issue_op_o,
  output logic                           issue_valid_o,
  output valu_pkg::vlen_t                issue_remaining_o,
  input  logic                           issue_word_done_i,
  input  valu_pkg::vlen_t                issue_elems_i,
  input  logic                           commit_i,
  output logic [valu_pkg::NrVInsn-1:0]   done_o
);
  import valu_pkg::*;

  // Stored operations, written at the accept pointer
  valu_op_t                insn_q [InsnQueueDepth];

  // One pointer per phase: accept, issue, commit
  logic [InsnPtrWidth-1:0] accept_pnt_d, accept_pnt_q;
  logic [InsnPtrWidth-1:0] issue_pnt_d, issue_pnt_q;
  logic [InsnPtrWidth-1:0] commit_pnt_d, commit_pnt_q;

  // Instructions still waiting to finish issue or commit
  logic [InsnPtrWidth:0]   issue_cnt_d, issue_cnt_q;
  logic [InsnPtrWidth:0]   commit_cnt_d, commit_cnt_q;

  // Remaining elements of the head instruction in each phase
  vlen_t                   issue_rem_d, issue_rem_q;
  vlen_t                   commit_rem_d, commit_rem_q;

  valu_op_t                commit_op;
  vlen_t                   commit_word_elems;
  logic                    accept;

  // Commit counter tracks everything in flight, so it decides fullness
  assign ready_o = (commit_cnt_q != InsnQueueDepth);
  assign accept  = op_valid_i && ready_o;

  assign issue_op_o        = insn_q[issue_pnt_q];
  assign issue_valid_o     = (issue_cnt_q != '0);
  assign issue_remaining_o = issue_rem_q;

  assign commit_op         = insn_q[commit_pnt_q];
  assign commit_word_elems = elems_per_word(commit_op.vsew);

  always_comb begin
    accept_pnt_d = accept_pnt_q;
    issue_pnt_d  = issue_pnt_q;
    commit_pnt_d = commit_pnt_q;
    issue_cnt_d  = issue_cnt_q;
    commit_cnt_d = commit_cnt_q;
    issue_rem_d  = issue_rem_q;
    commit_rem_d = commit_rem_q;
    done_o       = '0;

    // Issue phase, one word left the issue stage
    if (issue_word_done_i) begin
      issue_rem_d = issue_rem_q - issue_elems_i;
      if (issue_rem_d == '0) begin
        issue_cnt_d = issue_cnt_q - 1'b1;
        issue_pnt_d = issue_pnt_q + 1'b1;
        // Next pending instruction starts with its full vl
        if (issue_cnt_d != '0) begin
          issue_rem_d = insn_q[issue_pnt_d].vl;
        end
      end
    end

    // Commit phase, a granted word retires up to one word of elements
    if (commit_i) begin
      if (commit_rem_q <= commit_word_elems) begin
        commit_rem_d = '0;
      end else begin
        commit_rem_d = commit_rem_q - commit_word_elems;
      end
      if (commit_rem_d == '0) begin
        done_o[commit_op.id] = 1'b1;
        commit_cnt_d = commit_cnt_q - 1'b1;
        commit_pnt_d = commit_pnt_q + 1'b1;
        if (commit_cnt_d != '0) begin
          commit_rem_d = insn_q[commit_pnt_d].vl;
        end
      end
    end

    // Accept phase, load counters if the new op becomes the head
    if (accept) begin
      if (issue_cnt_d == '0) begin
        issue_rem_d = op_i.vl;
      end
      if (commit_cnt_d == '0) begin
        commit_rem_d = op_i.vl;
      end
      accept_pnt_d = accept_pnt_q + 1'b1;
      issue_cnt_d  = issue_cnt_d + 1'b1;
      commit_cnt_d = commit_cnt_d + 1'b1;
    end
  end

  // Operation storage
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_pnt_q] <= op_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      issue_rem_q  <= '0;
      commit_rem_q <= '0;
    end else begin
      accept_pnt_q <= accept_pnt_d;
      issue_pnt_q  <= issue_pnt_d;
      commit_pnt_q <= commit_pnt_d;
      issue_cnt_q  <= issue_cnt_d;
      commit_cnt_q <= commit_cnt_d;
      issue_rem_q  <= issue_rem_d;
      commit_rem_q <= commit_rem_d;
    end
  end

endmodule

/* simd_alu/simd_alu.sv */
`timescale 1ns/100ps

module simd_alu (
  input  rvv_pkg::elen_t   operand_a_i,
  input  rvv_pkg::elen_t   operand_b_i,
  input  rvv_pkg::alu_op_e op_i,
  input  rvv_pkg::vew_e    vew_i,
  output rvv_pkg::elen_t   result_o
);
  import rvv_pkg::*;

  // One full word of results per element width
  elen_t [3:0] width_res;
  logic        is_signed;

  // MINU and MAXU compare zero-extended lanes
  assign is_signed = op_i inside {VMIN, VMAX};

  // Same lane slice for every width, lanes never share a carry
  for (genvar w = 0; w < $size(VewBits); w++) begin : gen_width
    for (genvar l = 0; l < ElenWidth / VewBits[w]; l++) begin : gen_lane
      logic [VewBits[w]-1:0] a;
      logic [VewBits[w]-1:0] b;
      logic [VewBits[w]-1:0] r;
      logic                  a_lt_b;

      assign a = operand_a_i[l*VewBits[w] +: VewBits[w]];
      assign b = operand_b_i[l*VewBits[w] +: VewBits[w]];

      // Extra top bit is the sign only for signed compares
      assign a_lt_b = $signed({is_signed & a[VewBits[w]-1], a}) <
                      $signed({is_signed & b[VewBits[w]-1], b});

      always_comb begin
        case (op_i)
          VAND:        r = a & b;
          VOR:         r = a | b;
          VXOR:        r = a ^ b;
          VADD:        r = a + b;
          // vs2 minus vs1
          VSUB:        r = b - a;
          // Reverse form, scalar or vs1 minus vs2
          VRSUB:       r = a - b;
          VMIN, VMINU: r = a_lt_b ? a : b;
          VMAX, VMAXU: r = a_lt_b ? b : a;
          default:     r = '0;
        endcase
      end

      assign width_res[w][l*VewBits[w] +: VewBits[w]] = r;
    end
  end

  // Encoding of vew_i matches the width index
  assign result_o = width_res[vew_i];

endmodule

/* common/valu_pkg.sv */
package valu_pkg;

  // Instruction ids handed out by the sequencer
  localparam int unsigned NrVInsn = 8;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;

  // Register file geometry seen by this lane
  localparam int unsigned VRegWords = 4;
  localparam int unsigned NrVRegs   = 32;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;
  typedef logic [$clog2(NrVRegs*VRegWords)-1:0] vaddr_t;

  // Element count, 1 up to a full register of bytes (32)
  typedef logic [$clog2(VRegWords*rvv_pkg::ElenWidth/8):0] vlen_t;

  // Queue sizes, both powers of two so pointers wrap on their own
  localparam int unsigned InsnQueueDepth   = 4;
  localparam int unsigned ResultQueueDepth = 2;
  localparam int unsigned InsnPtrWidth     = $clog2(InsnQueueDepth);
  localparam int unsigned ResultPtrWidth   = $clog2(ResultQueueDepth);

  // Operation as delivered by the sequencer
  typedef struct packed {
    vid_t              id;
    rvv_pkg::alu_op_e  op;
    rvv_pkg::vew_e     vsew;
    vlen_t             vl;
    vreg_t             vd;
    logic              use_vs1;
    logic              use_vs2;
    logic              use_scalar_op;
    rvv_pkg::elen_t    scalar_op;
  } valu_op_t;

  // Register file write payload
  typedef struct packed {
    vid_t              id;
    vaddr_t            addr;
    rvv_pkg::elen_t    wdata;
    rvv_pkg::strb_t    be;
  } valu_result_t;

  // Elements packed into one datapath word: 8, 4, 2 or 1
  function automatic vlen_t elems_per_word(rvv_pkg::vew_e vsew);
    return vlen_t'(rvv_pkg::ElenWidth / 8) >> vsew;
  endfunction

endpackage

/* common/rvv_pkg.sv */
package rvv_pkg;

  // One datapath word holds a full 64-bit element or several narrower ones
  localparam int unsigned ElenWidth = 64;

  // Lane width in bits, indexed by the element-width encoding
  localparam int unsigned VewBits [4] = '{8, 16, 32, 64};

  typedef logic [ElenWidth-1:0] elen_t;

  // One write strobe per byte of the word
  typedef logic [ElenWidth/8-1:0] strb_t;

  // Standard element width encoding
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Integer ALU opcodes
  typedef enum logic [3:0] {
    VAND,
    VOR,
    VXOR,
    VADD,
    VSUB,
    VRSUB,
    VMIN,
    VMINU,
    VMAX,
    VMAXU
  } alu_op_e;

endpackage
